// File: rn_pkg.sv
`default_nettype none

package rn_pkg;

  // -------------------------------------------------------------------------
  // sizes
  // -------------------------------------------------------------------------
  // lanes per dispatch group
  localparam int DISP_SIZE  = 2;
  localparam int ARCH_REGS  = 32;
  localparam int ARCH_W     = $clog2(ARCH_REGS);
  // free-list depth per lane
  localparam int FLIST_SIZE = 32;
  // identity-mapped registers plus one free list per lane
  localparam int RNID_SIZE  = ARCH_REGS + DISP_SIZE * FLIST_SIZE;
  localparam int RNID_W     = $clog2(RNID_SIZE);
  localparam int WR_PORTS   = 2;

  typedef logic [RNID_W-1:0] rnid_t;
  typedef logic [ARCH_W-1:0] arch_t;

  // -------------------------------------------------------------------------
  // dispatch side
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic  valid;
    logic  rd_valid;
    arch_t rd_idx;
    logic  rs1_valid;
    arch_t rs1_idx;
    logic  rs2_valid;
    arch_t rs2_idx;
  } disp_inst_t;

  typedef disp_inst_t [DISP_SIZE-1:0] disp_group_t;

  // renamed instruction, dispatch fields first
  typedef struct packed {
    logic  valid;
    logic  rd_valid;
    arch_t rd_idx;
    logic  rs1_valid;
    arch_t rs1_idx;
    logic  rs2_valid;
    arch_t rs2_idx;
    rnid_t rd_rnid;
    rnid_t rd_old_rnid;
    rnid_t rs1_rnid;
    logic  rs1_ready;
    rnid_t rs2_rnid;
    logic  rs2_ready;
  } renamed_inst_t;

  typedef renamed_inst_t [DISP_SIZE-1:0] renamed_group_t;

  typedef rnid_t [DISP_SIZE-1:0] lane_rnids_t;

  // index 2*lane is rs1, 2*lane+1 is rs2
  typedef rnid_t [2*DISP_SIZE-1:0] src_rnids_t;

  // -------------------------------------------------------------------------
  // write-back and commit
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } phy_wr_t;

  typedef phy_wr_t [WR_PORTS-1:0] phy_wr_array_t;

  typedef struct packed {
    logic [DISP_SIZE-1:0] valid;
    lane_rnids_t          rnid;
  } commit_free_t;

endpackage

`default_nettype wire

// File: rn_freelist.sv
`timescale 1ns/1ps
`default_nettype none

module rn_freelist #(
  parameter int INIT_BASE = 32
) (
  input  wire                i_clk,
  input  wire                i_reset_n,
  input  wire                i_push,
  input  wire rn_pkg::rnid_t i_push_rnid,
  input  wire                i_pop,
  output rn_pkg::rnid_t      o_pop_rnid
);

  rn_pkg::rnid_t                         r_ring [rn_pkg::FLIST_SIZE];
  logic [$clog2(rn_pkg::FLIST_SIZE)-1:0] r_head;
  logic [$clog2(rn_pkg::FLIST_SIZE)-1:0] r_tail;
  logic [$clog2(rn_pkg::FLIST_SIZE):0]   r_count;

  logic w_empty;
  logic w_full;
  logic w_do_push;
  logic w_do_pop;

  assign w_empty = (r_count == '0);
  assign w_full  = (r_count == rn_pkg::FLIST_SIZE);

  // guard the ring against misuse, the caller is still expected to avoid it
  assign w_do_push = i_push & ~w_full;
  assign w_do_pop  = i_pop & ~w_empty;

  // head entry is the next rnid handed out
  assign o_pop_rnid = r_ring[r_head];

  // -------------------------------------------------------------------------
  // ring, pointers and occupancy
  // -------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // starts full, INIT_BASE upward
      for (int i = 0; i < rn_pkg::FLIST_SIZE; i++) begin
        r_ring[i] <= rn_pkg::rnid_t'(INIT_BASE + i);
      end
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= ($clog2(rn_pkg::FLIST_SIZE) + 1)'(rn_pkg::FLIST_SIZE);
    end else begin
      if (w_do_push) begin
        r_ring[r_tail] <= i_push_rnid;
        r_tail         <= r_tail + 1'b1;
      end
      if (w_do_pop) begin
        r_head <= r_head + 1'b1;
      end
      case ({w_do_push, w_do_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rn_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module rn_map_table (
  input  wire                       i_clk,
  input  wire                       i_reset_n,
  input  wire rn_pkg::disp_group_t  i_group,
  output rn_pkg::src_rnids_t        o_src_rnid,
  output rn_pkg::lane_rnids_t       o_rd_old_rnid,
  input  wire [rn_pkg::DISP_SIZE-1:0] i_alloc,
  input  wire rn_pkg::lane_rnids_t  i_alloc_rnid
);

  // architectural index to current physical id
  rn_pkg::rnid_t r_map [rn_pkg::ARCH_REGS];

  // -------------------------------------------------------------------------
  // lookups
  // -------------------------------------------------------------------------
  for (genvar d = 0; d < rn_pkg::DISP_SIZE; d++) begin : g_lookup
    assign o_src_rnid[2*d]   = r_map[i_group[d].rs1_idx];
    assign o_src_rnid[2*d+1] = r_map[i_group[d].rs2_idx];
    // previous mapping of rd, freed later at commit
    assign o_rd_old_rnid[d]  = r_map[i_group[d].rd_idx];
  end

  // -------------------------------------------------------------------------
  // group update
  // -------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // identity map, x0 stays at rnid 0 forever
      for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
        r_map[a] <= rn_pkg::rnid_t'(a);
      end
    end else begin
      // lane order, so a later lane to the same rd wins
      for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
        if (i_alloc[d]) begin
          r_map[i_group[d].rd_idx] <= i_alloc_rnid[d];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rn_inflight_list.sv
`timescale 1ns/1ps
`default_nettype none

module rn_inflight_list (
  input  wire                           i_clk,
  input  wire                           i_reset_n,
  input  wire rn_pkg::src_rnids_t       i_query_rnid,
  output logic [2*rn_pkg::DISP_SIZE-1:0] o_query_ready,
  input  wire [rn_pkg::DISP_SIZE-1:0]   i_alloc,
  input  wire rn_pkg::lane_rnids_t      i_alloc_rnid,
  input  wire rn_pkg::phy_wr_array_t    i_phy_wr
);

  // one bit per physical register, set means value produced
  logic [rn_pkg::RNID_SIZE-1:0] r_ready;
  logic [rn_pkg::RNID_SIZE-1:0] w_wb_hit;
  logic [rn_pkg::RNID_SIZE-1:0] w_alloc_clr;

  // decode write-back ports
  always_comb begin
    w_wb_hit = '0;
    for (int p = 0; p < rn_pkg::WR_PORTS; p++) begin
      if (i_phy_wr[p].valid) begin
        w_wb_hit[i_phy_wr[p].rnid] = 1'b1;
      end
    end
  end

  // decode newly allocated rds
  always_comb begin
    w_alloc_clr = '0;
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      if (i_alloc[d]) begin
        w_alloc_clr[i_alloc_rnid[d]] = 1'b1;
      end
    end
  end

  // stored bit or a write-back landing this cycle
  for (genvar q = 0; q < 2*rn_pkg::DISP_SIZE; q++) begin : g_query
    assign o_query_ready[q] = r_ready[i_query_rnid[q]] | w_wb_hit[i_query_rnid[q]];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      // allocation wins over a write-back to the same id
      r_ready <= (r_ready | w_wb_hit) & ~w_alloc_clr;
    end
  end

endmodule

`default_nettype wire

// File: rn_dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rn_dispatch_stage (
  input  wire                            i_clk,
  input  wire                            i_reset_n,
  input  wire                            i_disp_valid,
  input  wire rn_pkg::disp_group_t       i_group,
  output logic [rn_pkg::DISP_SIZE-1:0]   o_alloc,
  input  wire rn_pkg::lane_rnids_t       i_new_rnid,
  input  wire rn_pkg::src_rnids_t        i_src_rnid,
  input  wire rn_pkg::lane_rnids_t       i_rd_old_rnid,
  output rn_pkg::src_rnids_t             o_query_rnid,
  input  wire [2*rn_pkg::DISP_SIZE-1:0]  i_query_ready,
  output logic                           o_renamed_valid,
  output rn_pkg::renamed_group_t         o_renamed
);

  logic [rn_pkg::DISP_SIZE-1:0]   w_alloc;
  rn_pkg::lane_rnids_t            w_rd_rnid;
  rn_pkg::lane_rnids_t            w_rd_old_rnid;
  rn_pkg::src_rnids_t             w_src_rnid;
  logic [2*rn_pkg::DISP_SIZE-1:0] w_src_fwd;
  rn_pkg::renamed_group_t         w_renamed;

  logic                   r_valid;
  rn_pkg::renamed_group_t r_renamed;

  // -------------------------------------------------------------------------
  // allocation decision
  // -------------------------------------------------------------------------
  for (genvar d = 0; d < rn_pkg::DISP_SIZE; d++) begin : g_alloc
    // x0 is never renamed
    assign w_alloc[d] = i_disp_valid & i_group[d].valid & i_group[d].rd_valid &
                        (i_group[d].rd_idx != '0);
    assign w_rd_rnid[d] = w_alloc[d] ? i_new_rnid[d] : '0;
  end

  assign o_alloc = w_alloc;

  // -------------------------------------------------------------------------
  // intra-group forwarding
  // -------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      w_src_rnid[2*d]   = i_src_rnid[2*d];
      w_src_rnid[2*d+1] = i_src_rnid[2*d+1];
      w_src_fwd[2*d]    = 1'b0;
      w_src_fwd[2*d+1]  = 1'b0;
      w_rd_old_rnid[d]  = i_rd_old_rnid[d];
      // walk earlier lanes upward so the nearest one ends up winning
      for (int p = 0; p < d; p++) begin
        if (w_alloc[p] && (i_group[p].rd_idx == i_group[d].rs1_idx)) begin
          w_src_rnid[2*d] = w_rd_rnid[p];
          w_src_fwd[2*d]  = 1'b1;
        end
        if (w_alloc[p] && (i_group[p].rd_idx == i_group[d].rs2_idx)) begin
          w_src_rnid[2*d+1] = w_rd_rnid[p];
          w_src_fwd[2*d+1]  = 1'b1;
        end
        if (w_alloc[p] && (i_group[p].rd_idx == i_group[d].rd_idx)) begin
          w_rd_old_rnid[d] = w_rd_rnid[p];
        end
      end
    end
  end

  assign o_query_rnid = w_src_rnid;

  // -------------------------------------------------------------------------
  // renamed group assembly
  // -------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      w_renamed[d].valid       = i_group[d].valid;
      w_renamed[d].rd_valid    = i_group[d].rd_valid;
      w_renamed[d].rd_idx      = i_group[d].rd_idx;
      w_renamed[d].rs1_valid   = i_group[d].rs1_valid;
      w_renamed[d].rs1_idx     = i_group[d].rs1_idx;
      w_renamed[d].rs2_valid   = i_group[d].rs2_valid;
      w_renamed[d].rs2_idx     = i_group[d].rs2_idx;
      w_renamed[d].rd_rnid     = w_rd_rnid[d];
      w_renamed[d].rd_old_rnid = w_rd_old_rnid[d];
      w_renamed[d].rs1_rnid    = w_src_rnid[2*d];
      w_renamed[d].rs2_rnid    = w_src_rnid[2*d+1];
      // a producer in the same group cannot have written back yet
      w_renamed[d].rs1_ready   = ~w_src_fwd[2*d] & i_query_ready[2*d];
      w_renamed[d].rs2_ready   = ~w_src_fwd[2*d+1] & i_query_ready[2*d+1];
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_disp_valid;
    end
  end

  // payload only captured with the strobe
  always_ff @(posedge i_clk) begin
    if (i_disp_valid) begin
      r_renamed <= w_renamed;
    end
  end

  assign o_renamed_valid = r_valid;
  assign o_renamed       = r_renamed;

endmodule

`default_nettype wire

// File: rn_rename_top.sv
`timescale 1ns/1ps
`default_nettype none

module rn_rename_top (
  input  wire                          i_clk,
  input  wire                          i_reset_n,
  input  wire                          i_disp_valid,
  input  wire rn_pkg::disp_group_t     i_disp_group,
  input  wire rn_pkg::phy_wr_array_t   i_phy_wr,
  input  wire rn_pkg::commit_free_t    i_commit_free,
  output logic                         o_renamed_valid,
  output rn_pkg::renamed_group_t       o_renamed
);

  logic [rn_pkg::DISP_SIZE-1:0]   w_alloc;
  rn_pkg::lane_rnids_t            w_new_rnid;
  rn_pkg::src_rnids_t             w_src_rnid;
  rn_pkg::lane_rnids_t            w_rd_old_rnid;
  rn_pkg::src_rnids_t             w_query_rnid;
  logic [2*rn_pkg::DISP_SIZE-1:0] w_query_ready;

  // -------------------------------------------------------------------------
  // producer and consumer of allocations
  // -------------------------------------------------------------------------
  rn_dispatch_stage u_dispatch_stage (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_group         (i_disp_group),
    .o_alloc         (w_alloc),
    .i_new_rnid      (w_new_rnid),
    .i_src_rnid      (w_src_rnid),
    .i_rd_old_rnid   (w_rd_old_rnid),
    .o_query_rnid    (w_query_rnid),
    .i_query_ready   (w_query_ready),
    .o_renamed_valid (o_renamed_valid),
    .o_renamed       (o_renamed)
  );

  // one free list per lane, disjoint rnid ranges
  for (genvar d = 0; d < rn_pkg::DISP_SIZE; d++) begin : g_flist
    rn_freelist #(
      .INIT_BASE (rn_pkg::ARCH_REGS + rn_pkg::FLIST_SIZE * d)
    ) u_freelist (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_push      (i_commit_free.valid[d]),
      .i_push_rnid (i_commit_free.rnid[d]),
      .i_pop       (w_alloc[d]),
      .o_pop_rnid  (w_new_rnid[d])
    );
  end

  // -------------------------------------------------------------------------
  // lookup tables
  // -------------------------------------------------------------------------
  rn_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_group       (i_disp_group),
    .o_src_rnid    (w_src_rnid),
    .o_rd_old_rnid (w_rd_old_rnid),
    .i_alloc       (w_alloc),
    .i_alloc_rnid  (w_new_rnid)
  );

  rn_inflight_list u_inflight_list (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_query_rnid  (w_query_rnid),
    .o_query_ready (w_query_ready),
    .i_alloc       (w_alloc),
    .i_alloc_rnid  (w_new_rnid),
    .i_phy_wr      (i_phy_wr)
  );

endmodule

`default_nettype wire

// File: rn_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rn_freelist_sva (
  input wire                                i_clk,
  input wire                                i_reset_n,
  input wire                                i_push,
  input wire                                i_pop,
  input wire rn_pkg::rnid_t                 i_pop_rnid,
  input wire [$clog2(rn_pkg::FLIST_SIZE):0] i_count
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // ---------------------------------------------------------------------------
  // occupancy limits
  // ---------------------------------------------------------------------------
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> (i_count != '0))
  else begin
    fail_count++;
    $error("pop from an empty free list");
  end

  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> (i_count != rn_pkg::FLIST_SIZE))
  else begin
    fail_count++;
    $error("push into a full free list");
  end

  // head rnid always defined once out of reset
  a_known_head: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown(i_pop_rnid))
  else begin
    fail_count++;
    $error("free list head rnid is unknown");
  end

endmodule

bind rn_freelist rn_freelist_sva u_freelist_sva (
  .i_clk      (i_clk),
  .i_reset_n  (i_reset_n),
  .i_push     (i_push),
  .i_pop      (i_pop),
  .i_pop_rnid (o_pop_rnid),
  .i_count    (r_count)
);

`default_nettype wire

// File: rn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rn_tb;

  localparam int TIMEOUT = 20;

  logic                   clk;
  logic                   reset_n;
  logic                   disp_valid;
  rn_pkg::disp_group_t    disp_group;
  rn_pkg::phy_wr_array_t  phy_wr;
  rn_pkg::commit_free_t   commit_free;
  logic                   renamed_valid;
  rn_pkg::renamed_group_t renamed;

  // reference model state
  rn_pkg::rnid_t                m_map [rn_pkg::ARCH_REGS];
  rn_pkg::rnid_t                m_free [rn_pkg::DISP_SIZE][$];
  logic [rn_pkg::RNID_SIZE-1:0] m_ready;
  rn_pkg::renamed_group_t       exp_group;

  int errors;
  int tests_run;
  int tests_failed;

  rn_rename_top rn_rename_top_inst (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_disp_valid    (disp_valid),
    .i_disp_group    (disp_group),
    .i_phy_wr        (phy_wr),
    .i_commit_free   (commit_free),
    .o_renamed_valid (renamed_valid),
    .o_renamed       (renamed)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  task automatic model_reset();
    for (int a = 0; a < rn_pkg::ARCH_REGS; a++) begin
      m_map[a] = rn_pkg::rnid_t'(a);
    end
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      m_free[d].delete();
      for (int i = 0; i < rn_pkg::FLIST_SIZE; i++) begin
        m_free[d].push_back(rn_pkg::rnid_t'(rn_pkg::ARCH_REGS + rn_pkg::FLIST_SIZE * d + i));
      end
    end
    m_ready = '1;
  endtask

  // expected output for a group, then state as it stands after the edge
  task automatic predict_group(input rn_pkg::disp_group_t g, input rn_pkg::phy_wr_array_t wb,
                               input rn_pkg::commit_free_t cf);
    logic [rn_pkg::DISP_SIZE-1:0] alloc;
    rn_pkg::lane_rnids_t          new_rnid;
    logic [rn_pkg::RNID_SIZE-1:0] wb_hit;
    wb_hit = '0;
    for (int p = 0; p < rn_pkg::WR_PORTS; p++) begin
      if (wb[p].valid) begin
        wb_hit[wb[p].rnid] = 1'b1;
      end
    end
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      alloc[d] = g[d].valid && g[d].rd_valid && (g[d].rd_idx != '0);
      new_rnid[d] = alloc[d] ? m_free[d][0] : '0;
      exp_group[d].valid       = g[d].valid;
      exp_group[d].rd_valid    = g[d].rd_valid;
      exp_group[d].rd_idx      = g[d].rd_idx;
      exp_group[d].rs1_valid   = g[d].rs1_valid;
      exp_group[d].rs1_idx     = g[d].rs1_idx;
      exp_group[d].rs2_valid   = g[d].rs2_valid;
      exp_group[d].rs2_idx     = g[d].rs2_idx;
      exp_group[d].rd_rnid     = new_rnid[d];
      exp_group[d].rd_old_rnid = m_map[g[d].rd_idx];
      exp_group[d].rs1_rnid    = m_map[g[d].rs1_idx];
      exp_group[d].rs1_ready   = m_ready[m_map[g[d].rs1_idx]] | wb_hit[m_map[g[d].rs1_idx]];
      exp_group[d].rs2_rnid    = m_map[g[d].rs2_idx];
      exp_group[d].rs2_ready   = m_ready[m_map[g[d].rs2_idx]] | wb_hit[m_map[g[d].rs2_idx]];
      // nearest earlier producer wins
      for (int p = 0; p < d; p++) begin
        if (alloc[p] && (g[p].rd_idx == g[d].rs1_idx)) begin
          exp_group[d].rs1_rnid  = new_rnid[p];
          exp_group[d].rs1_ready = 1'b0;
        end
        if (alloc[p] && (g[p].rd_idx == g[d].rs2_idx)) begin
          exp_group[d].rs2_rnid  = new_rnid[p];
          exp_group[d].rs2_ready = 1'b0;
        end
        if (alloc[p] && (g[p].rd_idx == g[d].rd_idx)) begin
          exp_group[d].rd_old_rnid = new_rnid[p];
        end
      end
    end
    m_ready = m_ready | wb_hit;
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      if (alloc[d]) begin
        m_map[g[d].rd_idx] = new_rnid[d];
        m_ready[new_rnid[d]] = 1'b0;
        void'(m_free[d].pop_front());
      end
    end
    for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
      if (cf.valid[d]) begin
        m_free[d].push_back(cf.rnid[d]);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // compare and drive helpers
  // --------------------------------------------------------------------------
  task automatic check_renamed(input string name, input rn_pkg::renamed_inst_t got,
                               input rn_pkg::renamed_inst_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic rn_pkg::disp_inst_t make_inst(input logic v, input logic rdv,
                                                   input int rd, input int rs1, input int rs2);
    rn_pkg::disp_inst_t inst;
    inst.valid     = v;
    inst.rd_valid  = rdv;
    inst.rd_idx    = rn_pkg::arch_t'(rd);
    inst.rs1_valid = 1'b1;
    inst.rs1_idx   = rn_pkg::arch_t'(rs1);
    inst.rs2_valid = 1'b1;
    inst.rs2_idx   = rn_pkg::arch_t'(rs2);
    return inst;
  endfunction

  // one strobe, then wait for the renamed group and compare it
  task automatic send_group(input rn_pkg::disp_group_t g, input rn_pkg::phy_wr_array_t wb,
                            input rn_pkg::commit_free_t cf);
    int waited;
    disp_valid  = 1'b1;
    disp_group  = g;
    phy_wr      = wb;
    commit_free = cf;
    predict_group(g, wb, cf);
    @(posedge clk);
    #1;
    disp_valid  = 1'b0;
    phy_wr      = '0;
    commit_free = '0;
    waited = 0;
    while (!renamed_valid && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!renamed_valid) begin
      $display("timeout: no renamed group came back for the dispatch strobe");
      errors++;
    end else begin
      // the renamed group is due exactly one cycle after the strobe
      if (waited != 0) begin
        $display("renamed group came back %0d cycles later than one cycle", waited);
        errors++;
      end
      for (int d = 0; d < rn_pkg::DISP_SIZE; d++) begin
        check_renamed($sformatf("o_renamed[%0d]", d), renamed[d], exp_group[d]);
      end
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    int start;
    rn_pkg::disp_group_t g;
    start = errors;
    check_valid("o_renamed_valid", renamed_valid, 1'b0);
    g[0] = make_inst(1'b1, 1'b0, 0, 3, 7);
    g[1] = make_inst(1'b1, 1'b0, 0, 0, 31);
    send_group(g, '0, '0);
    @(posedge clk);
    #1;
    check_valid("o_renamed_valid", renamed_valid, 1'b0);
    finish_test("reset", start);
  endtask

  task automatic test_alloc_order();
    int start;
    rn_pkg::disp_group_t g;
    start = errors;
    g[0] = make_inst(1'b1, 1'b1, 5, 1, 2);
    g[1] = make_inst(1'b1, 1'b1, 6, 3, 4);
    send_group(g, '0, '0);
    // x0 in lane 1 takes nothing from its list
    g[0] = make_inst(1'b1, 1'b1, 5, 5, 6);
    g[1] = make_inst(1'b1, 1'b1, 0, 5, 0);
    send_group(g, '0, '0);
    g[0] = make_inst(1'b1, 1'b1, 0, 0, 0);
    g[1] = make_inst(1'b1, 1'b1, 9, 6, 5);
    send_group(g, '0, '0);
    finish_test("alloc_order", start);
  endtask

  task automatic test_forwarding();
    int start;
    rn_pkg::disp_group_t g;
    start = errors;
    g[0] = make_inst(1'b1, 1'b1, 10, 1, 2);
    g[1] = make_inst(1'b1, 1'b1, 10, 10, 10);
    send_group(g, '0, '0);
    g[0] = make_inst(1'b1, 1'b1, 11, 10, 3);
    g[1] = make_inst(1'b1, 1'b1, 13, 11, 12);
    send_group(g, '0, '0);
    finish_test("forwarding", start);
  endtask

  task automatic test_inflight();
    int start;
    rn_pkg::disp_group_t   g;
    rn_pkg::phy_wr_array_t wb;
    start = errors;
    g[0] = make_inst(1'b1, 1'b1, 14, 0, 0);
    g[1] = make_inst(1'b0, 1'b0, 0, 0, 0);
    send_group(g, '0, '0);
    g[0] = make_inst(1'b1, 1'b0, 0, 14, 14);
    send_group(g, '0, '0);
    // write-back in the lookup cycle on port 1
    wb = '0;
    wb[1].valid = 1'b1;
    wb[1].rnid  = m_map[14];
    send_group(g, wb, '0);
    send_group(g, '0, '0);
    finish_test("inflight", start);
  endtask

  task automatic test_recycle();
    int start;
    rn_pkg::disp_group_t  g;
    rn_pkg::commit_free_t cf;
    rn_pkg::rnid_t        prev_old;
    start = errors;
    prev_old = '0;
    for (int i = 0; i < 40; i++) begin
      g[0] = make_inst(1'b1, 1'b1, $urandom_range(31, 1), $urandom_range(31, 0),
                       $urandom_range(31, 0));
      g[1] = make_inst(1'b0, 1'b0, 0, 0, 0);
      cf = '0;
      if (i > 0) begin
        cf.valid[0] = 1'b1;
        cf.rnid[0]  = prev_old;
      end
      send_group(g, '0, cf);
      prev_old = exp_group[0].rd_old_rnid;
    end
    finish_test("recycle", start);
  endtask

  initial begin
    int unsigned seed;
    int          sva_fails;
    seed = 32'h6310_cfc5;
    void'($urandom(seed));
    reset_n      = 1'b0;
    disp_valid   = 1'b0;
    disp_group   = '0;
    phy_wr       = '0;
    commit_free  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_reset();
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    test_reset();
    test_alloc_order();
    test_forwarding();
    test_inflight();
    test_recycle();
    sva_fails = rn_rename_top_inst.g_flist[0].u_freelist.u_freelist_sva.fail_count +
                rn_rename_top_inst.g_flist[1].u_freelist.u_freelist_sva.fail_count;
    if (sva_fails != 0) begin
      $display("free-list assertions fired %0d times", sva_fails);
      errors += sva_fails;
    end
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
rn_pkg.sv
rn_freelist.sv
rn_map_table.sv
rn_inflight_list.sv
rn_dispatch_stage.sv
rn_rename_top.sv
rn_tb_sva.sv
rn_tb.sv
